// File: rtl/compress_stage.sv
module compress_stage
    import mul_pkg::*;
#(
    parameter int ROWS_IN = 4
) (
    input  prod_t [ROWS_IN-1:0]                            rows_i,
    output prod_t [((ROWS_IN > 2) ? ROWS_IN / 2 : 2)-1:0] rows_o
);

    if (ROWS_IN == 2) begin : g_final
        // already one sum row and one carry row
        assign rows_o = rows_i;
    end else begin : g_reduce
        for (genvar g = 0; g < ROWS_IN / 4; g++) begin : g_group
            // lowest column that can hold a one in this group
            localparam int LOW = g * 4 * (DATA_LEN / ROWS_IN);

            prod_t sum_row;
            prod_t carry_row;
            prod_t c_w;
            prod_t co_w;

            for (genvar j = 0; j < PROD_LEN; j++) begin : g_col
                if (j < LOW) begin : g_pass
                    assign sum_row[j]   = rows_i[4*g][j];
                    assign carry_row[j] = rows_i[4*g+1][j];
                end else begin : g_cell
                    logic cin;

                    if (j == LOW) begin : g_first
                        assign cin          = 1'b0;
                        assign carry_row[j] = 1'b0;
                    end else begin : g_chain
                        assign cin          = co_w[j-1];
                        assign carry_row[j] = c_w[j-1];
                    end

                    compressor_4to2 u_cmp (
                        .in1_i   (rows_i[4*g][j]),
                        .in2_i   (rows_i[4*g+1][j]),
                        .in3_i   (rows_i[4*g+2][j]),
                        .in4_i   (rows_i[4*g+3][j]),
                        .cin_i   (cin),
                        .sum_o   (sum_row[j]),
                        .carry_o (c_w[j]),
                        .cout_o  (co_w[j])
                    );
                end
            end

            // carries out of bit 63 fall away, product is mod 2^64
            assign rows_o[2*g]   = sum_row;
            assign rows_o[2*g+1] = carry_row;
        end
    end

endmodule

// File: rtl/compressor_4to2.sv
module compressor_4to2 (
    input  logic in1_i,
    input  logic in2_i,
    input  logic in3_i,
    input  logic in4_i,
    input  logic cin_i,
    output logic sum_o,
    output logic carry_o,
    output logic cout_o
);

    logic fa1_sum;

    // first full adder, no dependence on cin
    // so the column chain does not ripple
    assign fa1_sum = in1_i ^ in2_i ^ in3_i;
    assign cout_o  = (in1_i & in2_i) | (in1_i & in3_i) | (in2_i & in3_i);

    // second full adder folds in row four and the neighbor carry
    assign sum_o   = fa1_sum ^ in4_i ^ cin_i;
    assign carry_o = (fa1_sum & in4_i) | (fa1_sum & cin_i) | (in4_i & cin_i);

endmodule

// File: rtl/mul_pkg.sv
package mul_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_LEN      = 32;
    localparam int PROD_LEN      = 2 * DATA_LEN;
    localparam int FUNC3_WIDTH   = 3;
    localparam int ROB_TAG_WIDTH = 6;

    ////////////////////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [DATA_LEN-1:0]      data_t;
    typedef logic [PROD_LEN-1:0]      prod_t;
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

    // func3 of the M extension multiplies
    // codes 4 to 7 are handled like MUL
    typedef enum logic [FUNC3_WIDTH-1:0] {
        MUL_OP    = 3'd0,
        MULH_OP   = 3'd1,
        MULHSU_OP = 3'd2,
        MULHU_OP  = 3'd3
    } mul_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline structs
    ////////////////////////////////////////////////////////////////////////////

    // request from the issue side, 74 bits
    typedef struct packed {
        logic     valid;
        data_t    op1;
        data_t    op2;
        mul_op_e  op;
        rob_tag_t tag;
    } mul_req_t;

    // full product back to the consumer, 71 bits
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        prod_t    product;
    } mul_rsp_t;

    // first pipeline register, redundant form of the product
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        prod_t    sum;
        prod_t    carry;
    } tree_out_t;

endpackage

// File: rtl/mul_pp_gen.sv
module mul_pp_gen
    import mul_pkg::*;
(
    input  data_t                op1_i,
    input  data_t                op2_i,
    input  mul_op_e              op_i,
    output prod_t [DATA_LEN-1:0] rows_o
);

    logic  op1_signed;
    logic  op2_signed;
    logic  op1_sign;
    logic  op2_sign;
    data_t last_qual;

    // operand signedness per func3
    always_comb begin
        case (op_i)
            MUL_OP, MULH_OP: begin
                op1_signed = 1'b1;
                op2_signed = 1'b1;
            end
            MULHSU_OP: begin
                op1_signed = 1'b1;
                op2_signed = 1'b0;
            end
            MULHU_OP: begin
                op1_signed = 1'b0;
                op2_signed = 1'b0;
            end
            default: begin
                op1_signed = 1'b1;
                op2_signed = 1'b1;
            end
        endcase
    end

    assign op1_sign = op1_signed & op1_i[DATA_LEN-1];
    assign op2_sign = op2_signed & op2_i[DATA_LEN-1];

    // top bit of op2 weighs -2^31 when signed, so subtract op1 there
    always_comb begin
        if (!op2_i[DATA_LEN-1]) begin
            last_qual = '0;
        end else if (op2_signed) begin
            last_qual = ~op1_i + 1'b1;
        end else begin
            last_qual = op1_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // row placement
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < DATA_LEN - 1; i++) begin
            for (int j = 0; j < PROD_LEN; j++) begin
                if (j < i) begin
                    rows_o[i][j] = 1'b0;
                end else if (j < DATA_LEN + i) begin
                    rows_o[i][j] = op1_i[j-i] & op2_i[i];
                end else begin
                    // sign extension of the gated multiplicand
                    rows_o[i][j] = op1_sign & op2_i[i];
                end
            end
        end

        for (int j = 0; j < PROD_LEN - 1; j++) begin
            if (j < DATA_LEN - 1) begin
                rows_o[DATA_LEN-1][j] = 1'b0;
            end else begin
                rows_o[DATA_LEN-1][j] = last_qual[j-(DATA_LEN-1)];
            end
        end

        // sign correction on the msb of the last row
        rows_o[DATA_LEN-1][PROD_LEN-1] = (op1_sign ^ op2_sign) & op2_i[DATA_LEN-1]
                                         & last_qual[DATA_LEN-1];
    end

endmodule

// File: rtl/mul_tree.sv
module mul_tree
    import mul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  prod_t [DATA_LEN-1:0] rows_i,
    input  logic                 valid_i,
    input  rob_tag_t             tag_i,
    output tree_out_t            tree_out_o
);

    prod_t [DATA_LEN/2-1:0]  rows_l1;
    prod_t [DATA_LEN/4-1:0]  rows_l2;
    prod_t [DATA_LEN/8-1:0]  rows_l3;
    prod_t [DATA_LEN/16-1:0] rows_l4;
    prod_t [1:0]             rows_l5;

    ////////////////////////////////////////////////////////////////////////////
    // reduction levels, 32 rows down to 2
    ////////////////////////////////////////////////////////////////////////////

    compress_stage #(.ROWS_IN(DATA_LEN)) u_level1 (
        .rows_i (rows_i),
        .rows_o (rows_l1)
    );

    compress_stage #(.ROWS_IN(DATA_LEN / 2)) u_level2 (
        .rows_i (rows_l1),
        .rows_o (rows_l2)
    );

    compress_stage #(.ROWS_IN(DATA_LEN / 4)) u_level3 (
        .rows_i (rows_l2),
        .rows_o (rows_l3)
    );

    compress_stage #(.ROWS_IN(DATA_LEN / 8)) u_level4 (
        .rows_i (rows_l3),
        .rows_o (rows_l4)
    );

    compress_stage #(.ROWS_IN(DATA_LEN / 16)) u_level5 (
        .rows_i (rows_l4),
        .rows_o (rows_l5)
    );

    ////////////////////////////////////////////////////////////////////////////
    // first pipeline register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tree_out_o.valid <= 1'b0;
        end else begin
            tree_out_o.valid <= valid_i;
        end

        tree_out_o.tag   <= tag_i;
        tree_out_o.sum   <= rows_l5[0];
        tree_out_o.carry <= rows_l5[1];
    end

endmodule

// File: rtl/mul_unit.sv
module mul_unit
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  mul_req_t req_i,
    output mul_rsp_t rsp_o
);

    prod_t [DATA_LEN-1:0] pp_rows;
    tree_out_t            tree_out;
    prod_t                product;

    ////////////////////////////////////////////////////////////////////////////
    // partial products and compression, cycle 1
    ////////////////////////////////////////////////////////////////////////////

    mul_pp_gen u_pp_gen (
        .op1_i  (req_i.op1),
        .op2_i  (req_i.op2),
        .op_i   (req_i.op),
        .rows_o (pp_rows)
    );

    mul_tree u_tree (
        .clk        (clk),
        .reset_i    (reset_i),
        .rows_i     (pp_rows),
        .valid_i    (req_i.valid),
        .tag_i      (req_i.tag),
        .tree_out_o (tree_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // carry-propagate add, cycle 2
    ////////////////////////////////////////////////////////////////////////////

    assign product = tree_out.sum + tree_out.carry;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rsp_o.valid <= 1'b0;
        end else begin
            rsp_o.valid <= tree_out.valid;
        end

        // tag rides along with its product
        rsp_o.tag     <= tree_out.tag;
        rsp_o.product <= product;
    end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mul_unit_tb -f verilog.f -o mul_unit_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mul_unit_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: test/mul_unit_assert.sv
module mul_unit_assert
    import mul_pkg::*;
(
    input logic     clk,
    input logic     reset_i,
    input mul_req_t req_i,
    input mul_rsp_t rsp_i
);

    int       err_cnt = 0;
    logic     primed  = 1'b0;
    logic     rst_d1  = 1'b1;
    logic     rst_d2  = 1'b1;
    mul_req_t req_d1;
    mul_req_t req_d2;
    prod_t    exp_product;

    // product by the M extension rules, mod 2^64
    function automatic prod_t ref_product(input data_t a, input data_t b, input mul_op_e op);
        logic  a_signed;
        logic  b_signed;
        prod_t a_ext;
        prod_t b_ext;
        a_signed = (op != MULHU_OP);
        b_signed = (op != MULHU_OP) && (op != MULHSU_OP);
        a_ext    = {{DATA_LEN{a_signed & a[DATA_LEN-1]}}, a};
        b_ext    = {{DATA_LEN{b_signed & b[DATA_LEN-1]}}, b};
        return a_ext * b_ext;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // request history, two edges deep
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        primed <= 1'b1;
        rst_d1 <= reset_i;
        rst_d2 <= rst_d1;
        req_d1 <= req_i;
        req_d2 <= req_d1;
    end

    assign exp_product = ref_product(req_d2.op1, req_d2.op2, req_d2.op);

    ////////////////////////////////////////////////////////////////////////////
    // properties
    ////////////////////////////////////////////////////////////////////////////

    a_reset_valid: assert property (@(posedge clk)
        primed && (rst_d1 || rst_d2) |-> !rsp_i.valid)
    else begin
        $error("error rsp_o.valid 0x%h expected 0x0 around reset", $sampled(rsp_i.valid));
        err_cnt++;
    end

    a_valid_latency: assert property (@(posedge clk)
        primed && !rst_d1 && !rst_d2 |-> rsp_i.valid == req_d2.valid)
    else begin
        $error("error rsp_o.valid 0x%h expected 0x%h",
               $sampled(rsp_i.valid), $sampled(req_d2.valid));
        err_cnt++;
    end

    a_tag: assert property (@(posedge clk)
        primed && rsp_i.valid |-> rsp_i.tag == req_d2.tag)
    else begin
        $error("error rsp_o.tag 0x%h expected 0x%h",
               $sampled(rsp_i.tag), $sampled(req_d2.tag));
        err_cnt++;
    end

    a_product: assert property (@(posedge clk)
        primed && rsp_i.valid |-> rsp_i.product == exp_product)
    else begin
        $error("error rsp_o.product 0x%h expected 0x%h",
               $sampled(rsp_i.product), $sampled(exp_product));
        err_cnt++;
    end

endmodule

bind mul_unit mul_unit_assert u_assert (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req_i),
    .rsp_i   (rsp_o)
);

// File: test/mul_unit_tb.sv
module mul_unit_tb
    import mul_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CORNERS  = 5;
    localparam int NUM_DIRECTED = 4 * NUM_CORNERS * NUM_CORNERS;
    localparam int NUM_RANDOM   = 400;
    localparam int TIMEOUT      = (RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 10) * CLK_PERIOD;

    logic     clk;
    logic     reset;
    mul_req_t req;
    mul_rsp_t rsp;

    logic [15:0] lfsr_state;
    rob_tag_t    tag_ctr;
    int          req_cnt;
    int          rsp_cnt;
    int          err_total;

    data_t   corners [NUM_CORNERS];
    mul_op_e ops [4];

    mul_unit u_mul_unit (
        .clk     (clk),
        .reset_i (reset),
        .req_i   (req),
        .rsp_o   (rsp)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // responses counted away from the edge
    always @(negedge clk) begin
        if (!reset && rsp.valid) begin
            rsp_cnt++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic drive_req(input logic valid, input data_t op1, input data_t op2,
                             input mul_op_e op, input rob_tag_t tag);
        req.valid = valid;
        req.op1   = op1;
        req.op2   = op2;
        req.op    = op;
        req.tag   = tag;
        if (valid) begin
            req_cnt++;
        end
        @(posedge clk);
        #1;
    endtask

    // every corner pairing under every op, back to back
    task automatic run_directed();
        for (int k = 0; k < 4; k++) begin
            for (int a = 0; a < NUM_CORNERS; a++) begin
                for (int b = 0; b < NUM_CORNERS; b++) begin
                    drive_req(1'b1, corners[a], corners[b], ops[k], tag_ctr);
                    tag_ctr++;
                end
            end
        end
    endtask

    task automatic run_random();
        logic        valid;
        data_t       op1;
        data_t       op2;
        logic [31:0] op_bits;
        logic [31:0] tag_bits;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            // valid on about three of four cycles
            valid    = take_bits(2) != 32'd0;
            op1      = take_bits(DATA_LEN);
            op2      = take_bits(DATA_LEN);
            op_bits  = take_bits(FUNC3_WIDTH);
            tag_bits = take_bits(ROB_TAG_WIDTH);
            drive_req(valid, op1, op2, mul_op_e'(op_bits[FUNC3_WIDTH-1:0]),
                      tag_bits[ROB_TAG_WIDTH-1:0]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        req        = '0;
        lfsr_state = 16'd52;
        tag_ctr    = '0;
        req_cnt    = 0;
        rsp_cnt    = 0;
        err_total  = 0;

        // requests offered during reset must never come out
        req.valid  = 1'b1;

        corners[0] = 32'h0000_0000;
        corners[1] = 32'h0000_0001;
        corners[2] = 32'hFFFF_FFFF;
        corners[3] = 32'h8000_0000;
        corners[4] = 32'h7FFF_FFFF;
        ops[0]     = MUL_OP;
        ops[1]     = MULH_OP;
        ops[2]     = MULHSU_OP;
        ops[3]     = MULHU_OP;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        run_directed();
        run_random();

        // drain the two pipeline stages
        repeat (3) drive_req(1'b0, '0, '0, MUL_OP, '0);

        err_total = u_mul_unit.u_assert.err_cnt;
        $display("requests %0d, responses %0d, assertion errors %0d",
                 req_cnt, rsp_cnt, err_total);
        if (err_total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
rtl/mul_pkg.sv
rtl/compressor_4to2.sv
rtl/compress_stage.sv
rtl/mul_pp_gen.sv
rtl/mul_tree.sv
rtl/mul_unit.sv
test/mul_unit_assert.sv
test/mul_unit_tb.sv
